// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := blimp_core_tb
FILELIST  := blimp_core.f
OBJ_DIR   := obj_dir
PASS_MSG  := Regression passed

SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(filter-out +incdir+%,$(shell cat $(FILELIST))) $(wildcard hdl/*.svh)

.PHONY: all run clean

all: $(SIM_BIN)

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: blimp_core.f
+incdir+hdl
hdl/blimp_pkg.sv
hdl/fetch_unit.sv
hdl/decode_issue.sv
hdl/execute_unit.sv
hdl/blimp_core.sv
tb/blimp_core_tb.sv

// File: hdl/blimp_core.sv
/*
 * Blimp core top level
 * Fetch, decode/issue and execute between memory and trace ports
 */

`timescale 1ns/10ps
`default_nettype none

module blimp_core import blimp_pkg::*; (
  input  wire logic      clk,
  input  wire logic      reset,
  // Instruction memory
  output logic           mem_req_val,
  input  wire logic      mem_req_rdy,
  output mem_req_t       mem_req,
  input  wire logic      mem_resp_val,
  input  wire mem_resp_t mem_resp,
  // Retired instructions
  output logic           trace_val,
  output inst_trace_t    trace
);

  // ----------------------------------------
  // Stage links
  // ----------------------------------------

  logic   fetch_val;
  fetch_t fetch;
  logic   fetch_take;
  logic   exe_busy;
  logic   issue_val;
  issue_t issue;
  logic   wb_val;
  wb_t    wb;

  fetch_unit fetch_unit_i (
    .clk          (clk),
    .reset        (reset),
    .mem_req_val  (mem_req_val),
    .mem_req_rdy  (mem_req_rdy),
    .mem_req      (mem_req),
    .mem_resp_val (mem_resp_val),
    .mem_resp     (mem_resp),
    .fetch_val    (fetch_val),
    .fetch        (fetch),
    .fetch_take   (fetch_take)
  );

  // Register file lives here
  decode_issue decode_issue_i (
    .clk        (clk),
    .reset      (reset),
    .fetch_val  (fetch_val),
    .fetch      (fetch),
    .fetch_take (fetch_take),
    .exe_busy   (exe_busy),
    .issue_val  (issue_val),
    .issue      (issue),
    .wb_val     (wb_val),
    .wb         (wb)
  );

  execute_unit execute_unit_i (
    .clk       (clk),
    .reset     (reset),
    .issue_val (issue_val),
    .issue     (issue),
    .exe_busy  (exe_busy),
    .wb_val    (wb_val),
    .wb        (wb),
    .trace_val (trace_val),
    .trace     (trace)
  );

endmodule

`default_nettype wire

// File: hdl/blimp_macros.svh
/*
 * Blimp core sizing
 * Word width, request tag width and the first fetch address
 */

`ifndef BLIMP_MACROS_SVH
`define BLIMP_MACROS_SVH

// ----------------------------------------
// Datapath
// ----------------------------------------

// Data and address width
`define BLIMP_XLEN 32

// ----------------------------------------
// Memory interface
// ----------------------------------------

// Opaque tag carried by each instruction request
`define BLIMP_OPAQ_BITS 8

// First fetch address out of reset
`define BLIMP_RESET_PC 32'h0000_0000

`endif

// File: hdl/blimp_pkg.sv
/*
 * Blimp core types
 * Opcode and FSM encodings plus the records passed between stages
 */

`default_nettype none

`include "blimp_macros.svh"

package blimp_pkg;

  // ----------------------------------------
  // Encodings
  // ----------------------------------------

  // Operations that reach execute
  typedef enum logic [1:0] {
    OP_ADD,
    OP_ADDI,
    OP_MUL
  } inst_op_e;

  // Fetch FSM
  typedef enum logic [1:0] {
    F_IDLE,
    F_WAIT,
    F_FULL
  } fetch_state_e;

  // Iterative multiplier
  typedef enum logic {
    M_IDLE,
    M_BUSY
  } mul_state_e;

  // ----------------------------------------
  // Records
  // ----------------------------------------

  // Instruction memory request and response
  typedef struct packed {
    logic [`BLIMP_XLEN-1:0]      addr;
    logic [`BLIMP_OPAQ_BITS-1:0] opaque;
  } mem_req_t;

  typedef struct packed {
    logic [`BLIMP_XLEN-1:0]      data;
    logic [`BLIMP_OPAQ_BITS-1:0] opaque;
  } mem_resp_t;

  // Buffered word and its address
  typedef struct packed {
    logic [`BLIMP_XLEN-1:0] pc;
    logic [`BLIMP_XLEN-1:0] inst;
  } fetch_t;

  // Operand b is rs2 or the immediate, already chosen
  typedef struct packed {
    inst_op_e               op;
    logic [`BLIMP_XLEN-1:0] pc;
    logic [4:0]             rd;
    logic [`BLIMP_XLEN-1:0] a;
    logic [`BLIMP_XLEN-1:0] b;
  } issue_t;

  // Register file write
  typedef struct packed {
    logic [4:0]             rd;
    logic [`BLIMP_XLEN-1:0] data;
  } wb_t;

  // One retired instruction
  typedef struct packed {
    logic [`BLIMP_XLEN-1:0] pc;
    logic [4:0]             waddr;
    logic [`BLIMP_XLEN-1:0] wdata;
    logic                   wen;
  } inst_trace_t;

endpackage

`default_nettype wire

// File: hdl/decode_issue.sv
/*
 * Decode and issue
 * RV32 decode for ADDI, ADD and MUL, register file read and issue
 */

`timescale 1ns/10ps
`default_nettype none

`include "blimp_macros.svh"

module decode_issue import blimp_pkg::*; (
  input  wire logic   clk,
  input  wire logic   reset,
  input  wire logic   fetch_val,
  input  wire fetch_t fetch,
  output logic        fetch_take,
  input  wire logic   exe_busy,
  output logic        issue_val,
  output issue_t      issue,
  input  wire logic   wb_val,
  input  wire wb_t    wb
);

  // RV32 major opcodes and the M extension funct7
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] F7_BASE    = 7'b0000000;
  localparam logic [6:0] F7_MULDIV  = 7'b0000001;

  logic [`BLIMP_XLEN-1:0] rf [32];

  logic [`BLIMP_XLEN-1:0] inst;
  logic [6:0]             opcode;
  logic [2:0]             funct3;
  logic [6:0]             funct7;
  logic [4:0]             rd;
  logic [4:0]             rs1;
  logic [4:0]             rs2;
  logic [`BLIMP_XLEN-1:0] imm_i;
  logic [`BLIMP_XLEN-1:0] rs1_val;
  logic [`BLIMP_XLEN-1:0] rs2_val;
  logic                   is_addi;
  logic                   is_add;
  logic                   is_mul;
  logic                   legal;
  inst_op_e               op;

  // ----------------------------------------
  // Field extraction
  // ----------------------------------------

  assign inst   = fetch.inst;
  assign opcode = inst[6:0];
  assign rd     = inst[11:7];
  assign funct3 = inst[14:12];
  assign rs1    = inst[19:15];
  assign rs2    = inst[24:20];
  assign funct7 = inst[31:25];
  assign imm_i  = {{(`BLIMP_XLEN-12){inst[31]}}, inst[31:20]};

  assign is_addi = (opcode == OPC_OP_IMM) && (funct3 == 3'b000);
  assign is_add  = (opcode == OPC_OP) && (funct3 == 3'b000) && (funct7 == F7_BASE);
  assign is_mul  = (opcode == OPC_OP) && (funct3 == 3'b000) && (funct7 == F7_MULDIV);
  assign legal   = is_addi | is_add | is_mul;

  always_comb begin
    op = OP_ADDI;
    if (is_add) begin
      op = OP_ADD;
    end else if (is_mul) begin
      op = OP_MUL;
    end
  end

  // ----------------------------------------
  // Register file
  // ----------------------------------------

  // Execute never sends a write to x0
  always_ff @(posedge clk) begin
    if (wb_val) begin
      rf[wb.rd] <= wb.data;
    end
  end

  // x0 is zero, same-cycle writeback wins over the array
  assign rs1_val = (rs1 == 5'd0) ? '0 :
                   (wb_val && (wb.rd == rs1)) ? wb.data : rf[rs1];
  assign rs2_val = (rs2 == 5'd0) ? '0 :
                   (wb_val && (wb.rd == rs2)) ? wb.data : rf[rs2];

  // ----------------------------------------
  // Issue
  // ----------------------------------------

  // Take and issue together whenever execute is free
  assign fetch_take = fetch_val && !exe_busy;
  // Unknown words get dropped here
  assign issue_val  = fetch_take && legal;

  assign issue.op = op;
  assign issue.pc = fetch.pc;
  assign issue.rd = rd;
  assign issue.a  = rs1_val;
  assign issue.b  = is_addi ? imm_i : rs2_val;

  // Program holds only the supported instructions
  legal_inst_a: assert property (@(posedge clk) disable iff (reset)
    fetch_take |-> legal);

endmodule

`default_nettype wire

// File: hdl/execute_unit.sv
/*
 * Execute unit
 * Single-cycle adder and shift-add multiplier, retires in order
 */

`timescale 1ns/10ps
`default_nettype none

`include "blimp_macros.svh"

module execute_unit import blimp_pkg::*; (
  input  wire logic   clk,
  input  wire logic   reset,
  input  wire logic   issue_val,
  input  wire issue_t issue,
  output logic        exe_busy,
  output logic        wb_val,
  output wb_t         wb,
  output logic        trace_val,
  output inst_trace_t trace
);

  mul_state_e             mul_state_r;
  logic [`BLIMP_XLEN-1:0] acc_r;
  logic [`BLIMP_XLEN-1:0] mcand_r;
  logic [`BLIMP_XLEN-1:0] mplier_r;
  logic [4:0]             bit_cnt_r;
  logic [`BLIMP_XLEN-1:0] acc_next;
  logic                   mul_done;
  logic                   is_mul;

  // Retirement record
  logic                   ret_val_r;
  logic [`BLIMP_XLEN-1:0] ret_pc_r;
  logic [4:0]             ret_rd_r;
  logic [`BLIMP_XLEN-1:0] ret_data_r;

  assign is_mul   = (issue.op == OP_MUL);
  assign acc_next = acc_r + (mplier_r[0] ? mcand_r : '0);
  // Bit 0 is done at issue, bit 31 on the last busy cycle
  assign mul_done = (mul_state_r == M_BUSY) && (bit_cnt_r == 5'd31);
  assign exe_busy = (mul_state_r == M_BUSY);

  // ----------------------------------------
  // Control
  // ----------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      mul_state_r <= M_IDLE;
      ret_val_r   <= 1'b0;
    end else begin
      ret_val_r <= (issue_val && !is_mul) || mul_done;
      case (mul_state_r)
        M_IDLE: begin
          if (issue_val && is_mul) begin
            mul_state_r <= M_BUSY;
          end
        end
        M_BUSY: begin
          if (mul_done) begin
            mul_state_r <= M_IDLE;
          end
        end
        default: mul_state_r <= M_IDLE;
      endcase
    end
  end

  // ----------------------------------------
  // Datapath
  // ----------------------------------------

  always_ff @(posedge clk) begin
    if (issue_val) begin
      ret_pc_r   <= issue.pc;
      ret_rd_r   <= issue.rd;
      // ADD and ADDI share the adder
      ret_data_r <= issue.a + issue.b;
      acc_r      <= issue.b[0] ? issue.a : '0;
      mcand_r    <= issue.a << 1;
      mplier_r   <= issue.b >> 1;
      bit_cnt_r  <= 5'd1;
    end else if (exe_busy) begin
      acc_r     <= acc_next;
      mcand_r   <= mcand_r << 1;
      mplier_r  <= mplier_r >> 1;
      bit_cnt_r <= bit_cnt_r + 5'd1;
      if (mul_done) begin
        ret_data_r <= acc_next;
      end
    end
  end

  // Writes to x0 retire without a register write
  assign wb_val  = ret_val_r && (ret_rd_r != 5'd0);
  assign wb.rd   = ret_rd_r;
  assign wb.data = ret_data_r;

  assign trace_val   = ret_val_r;
  assign trace.pc    = ret_pc_r;
  assign trace.waddr = ret_rd_r;
  assign trace.wdata = ret_data_r;
  assign trace.wen   = (ret_rd_r != 5'd0);

  // Decode holds off while the multiplier runs
  no_issue_busy_a: assert property (@(posedge clk) disable iff (reset)
    exe_busy |-> !issue_val);

endmodule

`default_nettype wire

// File: hdl/fetch_unit.sv
/*
 * Fetch unit
 * Issues tagged instruction requests and buffers one word for decode
 */

`timescale 1ns/10ps
`default_nettype none

`include "blimp_macros.svh"

module fetch_unit import blimp_pkg::*; (
  input  wire logic      clk,
  input  wire logic      reset,
  output logic           mem_req_val,
  input  wire logic      mem_req_rdy,
  output mem_req_t       mem_req,
  input  wire logic      mem_resp_val,
  input  wire mem_resp_t mem_resp,
  output logic           fetch_val,
  output fetch_t         fetch,
  input  wire logic      fetch_take
);

  fetch_state_e                state_r;
  logic [`BLIMP_XLEN-1:0]      pc_r;
  logic [`BLIMP_OPAQ_BITS-1:0] tag_r;
  logic                        req_val_r;
  logic [`BLIMP_XLEN-1:0]      inst_r;
  logic [`BLIMP_XLEN-1:0]      next_pc;
  logic [`BLIMP_OPAQ_BITS-1:0] next_tag;
  logic                        take_now;
  logic                        resp_hit;

  assign next_pc  = pc_r + `BLIMP_XLEN'd4;
  assign next_tag = tag_r + 1'b1;
  assign take_now = (state_r == F_FULL) && fetch_take;

  // Response only counts once the request left and the tag matches
  assign resp_hit = mem_resp_val && (state_r == F_WAIT) && !req_val_r &&
                    (mem_resp.opaque == tag_r);

  // ----------------------------------------
  // Request port
  // ----------------------------------------

  // Next request goes out in the take cycle, then the register holds it
  assign mem_req_val    = req_val_r | take_now;
  assign mem_req.addr   = take_now ? next_pc : pc_r;
  assign mem_req.opaque = take_now ? next_tag : tag_r;

  always_ff @(posedge clk) begin
    if (reset) begin
      state_r   <= F_IDLE;
      pc_r      <= `BLIMP_RESET_PC;
      tag_r     <= '0;
      req_val_r <= 1'b0;
    end else begin
      case (state_r)
        // First request after reset
        F_IDLE: begin
          req_val_r <= 1'b1;
          state_r   <= F_WAIT;
        end
        F_WAIT: begin
          if (req_val_r && mem_req_rdy) begin
            req_val_r <= 1'b0;
          end
          if (resp_hit) begin
            state_r <= F_FULL;
          end
        end
        // Word held until decode takes it
        F_FULL: begin
          if (fetch_take) begin
            pc_r      <= next_pc;
            tag_r     <= next_tag;
            req_val_r <= !mem_req_rdy;
            state_r   <= F_WAIT;
          end
        end
        default: state_r <= F_IDLE;
      endcase
    end
  end

  // Instruction buffer
  always_ff @(posedge clk) begin
    if (resp_hit) begin
      inst_r <= mem_resp.data;
    end
  end

  assign fetch_val  = (state_r == F_FULL);
  assign fetch.pc   = pc_r;
  assign fetch.inst = inst_r;

  // Memory answers only accepted requests, with the outstanding tag
  resp_tag_a: assert property (@(posedge clk) disable iff (reset)
    mem_resp_val |-> (state_r == F_WAIT) && !req_val_r && (mem_resp.opaque == tag_r));

endmodule

`default_nettype wire

// File: tb/blimp_core_cases.txt
# Each test opens with a line: test <name>
# Then one line per instruction, all hex: <inst word> <trace pc> <waddr> <wdata> <wen>
test addi_imm
00500093 00000000 01 00000005 1
FFD08113 00000004 02 00000002 1
7FF10193 00000008 03 00000801 1
80000213 0000000C 04 FFFFF800 1
FFF20293 00000010 05 FFFFF7FF 1
06418F93 00000014 1F 00000865 1

test add_chain
00700093 00000000 01 00000007 1
00900113 00000004 02 00000009 1
002081B3 00000008 03 00000010 1
00318233 0000000C 04 00000020 1
00120233 00000010 04 00000027 1
003202B3 00000014 05 00000037 1
00028333 00000018 06 00000037 1

test mul_low
00C00093 00000000 01 0000000C 1
FF900113 00000004 02 FFFFFFF9 1
021081B3 00000008 03 00000090 1
02208233 0000000C 04 FFFFFFAC 1
022102B3 00000010 05 00000031 1
02020333 00000014 06 00000000 1
00118393 00000018 07 00000091 1
02728433 0000001C 08 00001BC1 1
7FF00513 00000020 0A 000007FF 1
02A205B3 00000024 0B FFFD6054 1
02B58633 00000028 0C E2471B90 1

test x0_reg
00500013 00000000 00 00000005 0
00300093 00000004 01 00000003 1
00108033 00000008 00 00000006 0
00000113 0000000C 02 00000000 1
001001B3 00000010 03 00000003 1
02108033 00000014 00 00000009 0
FFF00213 00000018 04 FFFFFFFF 1

test stall_mix
00100093 00000000 01 00000001 1
001080B3 00000004 01 00000002 1
001080B3 00000008 01 00000004 1
001080B3 0000000C 01 00000008 1
02108133 00000010 02 00000040 1
FC010113 00000014 02 00000000 1
001101B3 00000018 03 00000008 1
12318193 0000001C 03 0000012B 1

// File: tb/blimp_core_tb.sv
/*
 * Blimp core testbench
 * Plays the instruction memory with random stalls and checks the trace stream
 */

`timescale 1ns/10ps
`default_nettype none

module blimp_core_tb import blimp_pkg::*; ();

  localparam int    CLK_PERIOD  = 20;
  localparam int    MAX_TESTS   = 16;
  localparam int    MAX_RECORDS = 128;
  localparam string CASES_FILE  = "tb/blimp_core_cases.txt";

  logic        clk = 1'b0;
  logic        reset;
  logic        mem_req_val;
  logic        mem_req_rdy;
  mem_req_t    mem_req;
  logic        mem_resp_val;
  mem_resp_t   mem_resp;
  logic        trace_val;
  inst_trace_t trace;

  // Cases flattened to one program word and one trace record per line
  string       test_name [MAX_TESTS];
  int          test_base [MAX_TESTS];
  int          test_len  [MAX_TESTS];
  logic [31:0] prog_mem  [MAX_RECORDS];
  inst_trace_t exp_rec   [MAX_RECORDS];
  int          n_tests;
  int          n_records;

  // Run state
  integer      seed;
  logic        loaded = 1'b0;
  int          watchdog_cycles;
  int          errors;
  int          passed;
  int          failed;
  int          cur_base;
  int          cur_len;
  int          got;
  int          req_count;

  // Outstanding memory response
  logic        pend;
  int          pend_wait;
  logic [31:0] pend_data;
  logic [7:0]  pend_tag;

  always #(CLK_PERIOD/2) clk = ~clk;

  blimp_core blimp_core_i (
    .clk          (clk),
    .reset        (reset),
    .mem_req_val  (mem_req_val),
    .mem_req_rdy  (mem_req_rdy),
    .mem_req      (mem_req),
    .mem_resp_val (mem_resp_val),
    .mem_resp     (mem_resp),
    .trace_val    (trace_val),
    .trace        (trace)
  );

  // ----------------------------------------
  // Helpers
  // ----------------------------------------

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      $display("[FAIL] %0t ns: %s expected %h, got %h", $time, name, expected, actual);
      errors++;
    end
  endtask

  // Header line opens each test and data lines follow
  task automatic load_cases();
    int          fd;
    string       line;
    string       name;
    logic [31:0] word;
    logic [31:0] pc;
    logic [31:0] waddr;
    logic [31:0] wdata;
    logic [31:0] wen;
    fd = $fopen(CASES_FILE, "r");
    n_tests   = 0;
    n_records = 0;
    if (fd == 0) begin
      $display("Cannot open %s for reading", CASES_FILE);
      errors++;
    end else begin
      while ($fgets(line, fd) > 0) begin
        if (line.len() < 2 || line.getc(0) == "#") begin
          // Blank or comment
        end else if ($sscanf(line, "test %s", name) == 1) begin
          test_name[n_tests] = name;
          test_base[n_tests] = n_records;
          test_len[n_tests]  = 0;
          n_tests++;
        end else if ($sscanf(line, "%h %h %h %h %h", word, pc, waddr, wdata, wen) == 5 &&
                     n_tests > 0) begin
          prog_mem[n_records]      = word;
          exp_rec[n_records].pc    = pc;
          exp_rec[n_records].waddr = waddr[4:0];
          exp_rec[n_records].wdata = wdata;
          exp_rec[n_records].wen   = wen[0];
          n_records++;
          test_len[n_tests-1]++;
        end
      end
      $fclose(fd);
    end
  endtask

  // Per falling edge check the trace, answer memory and pick rdy
  task automatic cycle_step();
    inst_trace_t expected;
    int          idx;
    if (trace_val) begin
      if (got < cur_len) begin
        expected = exp_rec[cur_base + got];
        check_value("trace.pc", expected.pc, trace.pc);
        check_value("trace.waddr", 32'(expected.waddr), 32'(trace.waddr));
        check_value("trace.wdata", expected.wdata, trace.wdata);
        check_value("trace.wen", 32'(expected.wen), 32'(trace.wen));
      end else begin
        $display("Unexpected extra trace record at %0t ns, pc %h", $time, trace.pc);
        errors++;
      end
      got++;
    end
    // Response strobe lasts one cycle
    mem_resp_val = 1'b0;
    if (pend) begin
      if (pend_wait == 0) begin
        mem_resp_val    = 1'b1;
        mem_resp.data   = pend_data;
        mem_resp.opaque = pend_tag;
        pend            = 1'b0;
      end else begin
        pend_wait--;
      end
    end
    // mem_req_val comes from core registers, so it is stable here
    mem_req_rdy = (($unsigned($random(seed)) % 4) != 0);
    if (mem_req_val && mem_req_rdy) begin
      // Sequential fetch from the reset pc with one new tag per request
      check_value("mem_req.addr", 32'(4 * req_count), mem_req.addr);
      check_value("mem_req.opaque", 32'(req_count % 256), 32'(mem_req.opaque));
      req_count++;
      idx = int'(mem_req.addr >> 2);
      // Fetches past the program stay unanswered
      if (mem_req.addr[1:0] == 2'b00 && idx >= 0 && idx < cur_len) begin
        pend      = 1'b1;
        pend_wait = $unsigned($random(seed)) % 4;
        pend_data = prog_mem[cur_base + idx];
        pend_tag  = mem_req.opaque;
      end
    end
  endtask

  task automatic apply_reset();
    @(negedge clk);
    reset        = 1'b1;
    mem_req_rdy  = 1'b0;
    mem_resp_val = 1'b0;
    pend         = 1'b0;
    req_count    = 0;
    repeat (2) @(negedge clk);
    reset = 1'b0;
  endtask

  task automatic run_test(input int t);
    int errs_before;
    int limit;
    int cycles;
    errs_before = errors;
    cur_base    = test_base[t];
    cur_len     = test_len[t];
    got         = 0;
    apply_reset();
    limit  = 40 * cur_len + 10;
    cycles = 0;
    while (got < cur_len && cycles < limit) begin
      @(negedge clk);
      cycle_step();
      cycles++;
    end
    // Short drain catches extra retirements
    repeat (4) begin
      @(negedge clk);
      cycle_step();
    end
    if (got < cur_len) begin
      $display("Only %0d of %0d trace records arrived in %0d cycles", got, cur_len, limit);
      errors++;
    end
    if (errors == errs_before) begin
      passed++;
      $display("test %0s: ok, %0d traces", test_name[t], cur_len);
    end else begin
      failed++;
      $display("test %0s: FAILED with %0d errors", test_name[t], errors - errs_before);
    end
  endtask

  // ----------------------------------------
  // Main sequence
  // ----------------------------------------

  initial begin
    reset        = 1'b1;
    mem_req_rdy  = 1'b0;
    mem_resp_val = 1'b0;
    mem_resp     = '0;
    seed         = 65;
    errors       = 0;
    passed       = 0;
    failed       = 0;
    got          = 0;
    cur_base     = 0;
    cur_len      = 0;
    req_count    = 0;
    pend         = 1'b0;
    pend_wait    = 0;
    load_cases();
    watchdog_cycles = 40 * n_records + 100;
    loaded          = 1'b1;
    for (int t = 0; t < n_tests; t++) begin
      run_test(t);
    end
    $display("%0d tests, %0d passed, %0d failed, %0d errors", n_tests, passed, failed, errors);
    if (n_tests > 0 && failed == 0 && errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

  // Watchdog sized from the number of expected records
  initial begin
    wait (loaded);
    repeat (watchdog_cycles) @(posedge clk);
    $display("Watchdog expired after %0d cycles, the run did not complete", watchdog_cycles);
    $display("Regression failed");
    $finish;
  end

endmodule

`default_nettype wire
